// ==== all.f ====
src/core_pkg.sv
src/rob_pkg.sv
src/free_list.sv
src/rename_map.sv
src/retire_queue.sv
src/rename_core.sv
verification/tb_rename_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rename_core -f all.f \
    -o sim_rename > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_rename > sim.log 2>&1 || true
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // Register naming of the core
    localparam int ARCH_REGS = 32;  // Architectural registers seen by software
    localparam int PREGS     = 48;  // Physical registers behind the rename map

    // Architectural register index, 0 to 31
    typedef logic [4:0] arch_reg_t;

    // Physical register tag, 0 to 47
    typedef logic [5:0] phys_reg_t;

endpackage

`default_nettype wire

// ==== src/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int PHYS_REGS  = core_pkg::PREGS,
    parameter int FREE_PORTS = rob_pkg::COMMIT_WIDTH
)(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  alloc_en,
    input  wire logic [FREE_PORTS-1:0] free_en,
    input  wire core_pkg::phys_reg_t   free_phys [FREE_PORTS],
    output core_pkg::phys_reg_t        alloc_phys,
    output logic                       alloc_valid
);

    logic [PHYS_REGS-1:0] free_mask;    // 1 = free
    logic [PHYS_REGS-1:0] merged_mask;  // Mask with this cycle's frees applied
    logic [PHYS_REGS-1:0] next_mask;
    logic                 pick_found;
    core_pkg::phys_reg_t  pick_idx;

    // Frees go in first so a tag retired this cycle can be handed out again
    always_comb begin
        merged_mask = free_mask;
        for (int j = 0; j < FREE_PORTS; j++) begin
            if (free_en[j]) merged_mask[free_phys[j]] = 1'b1;
        end

        // Priority search, lowest free index wins
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            if (merged_mask[i] && !pick_found) begin
                pick_found = 1'b1;
                pick_idx   = core_pkg::phys_reg_t'(i);
            end
        end

        next_mask = merged_mask;
        if (alloc_en && pick_found) next_mask[pick_idx] = 1'b0;  // Claim it
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                free_mask[i] <= (i >= core_pkg::ARCH_REGS);  // Identity-mapped regs are busy
            end
            alloc_valid <= 1'b0;
        end else begin
            free_mask   <= next_mask;
            alloc_valid <= alloc_en && pick_found;  // Low on a dry pool
        end
    end

    // Claimed tag, qualified by alloc_valid
    always_ff @(posedge clk) begin
        if (alloc_en) alloc_phys <= pick_idx;
    end

endmodule

`default_nettype wire

// ==== src/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                rename_req,
    input  wire core_pkg::arch_reg_t src1_arch,
    input  wire core_pkg::arch_reg_t src2_arch,
    input  wire core_pkg::arch_reg_t dest_arch,
    input  wire logic [1:0]          commit_count,
    output logic                     rename_done,
    output logic                     rename_fail,
    output core_pkg::phys_reg_t      src1_phys,
    output core_pkg::phys_reg_t      src2_phys,
    output core_pkg::phys_reg_t      dest_phys,
    output core_pkg::phys_reg_t      old_phys,
    output logic [1:0]               retire_valid,
    output core_pkg::phys_reg_t      retired_old_phys0,
    output core_pkg::phys_reg_t      retired_old_phys1,
    output rob_pkg::credit_t         credit_return
);

    logic                req_q;        // Request seen last cycle
    logic                alloc_valid;
    core_pkg::phys_reg_t alloc_phys;
    core_pkg::arch_reg_t pending_arch;
    core_pkg::phys_reg_t free_phys [rob_pkg::COMMIT_WIDTH];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) req_q <= 1'b0;
        else req_q <= rename_req;
    end

    assign rename_done = alloc_valid;             // Only set after a request
    assign rename_fail = req_q && !alloc_valid;   // Pool was empty
    assign free_phys[0] = retired_old_phys0;
    assign free_phys[1] = retired_old_phys1;

    free_list u_free_list (
        .clk         (clk),
        .reset       (reset),
        .alloc_en    (rename_req),
        .free_en     (retire_valid),
        .free_phys   (free_phys),
        .alloc_phys  (alloc_phys),
        .alloc_valid (alloc_valid)
    );

    rename_map u_rename_map (
        .clk          (clk),
        .reset        (reset),
        .src1_arch    (src1_arch),
        .src2_arch    (src2_arch),
        .dest_arch    (dest_arch),
        .lookup_en    (rename_req),
        .alloc_phys   (alloc_phys),
        .alloc_valid  (alloc_valid),
        .src1_phys    (src1_phys),
        .src2_phys    (src2_phys),
        .dest_phys    (dest_phys),
        .old_phys     (old_phys),
        .pending_arch (pending_arch)
    );

    // Successful renames enter the queue in the cycle they are reported
    retire_queue u_retire_queue (
        .clk           (clk),
        .reset         (reset),
        .push          (rename_done),
        .push_arch     (pending_arch),
        .push_old_phys (old_phys),
        .rename_fail   (rename_fail),
        .commit_count  (commit_count),
        .free_en       (retire_valid),
        .free_phys0    (retired_old_phys0),
        .free_phys1    (retired_old_phys1),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// ==== src/rename_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_map (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire core_pkg::arch_reg_t src1_arch,
    input  wire core_pkg::arch_reg_t src2_arch,
    input  wire core_pkg::arch_reg_t dest_arch,
    input  wire logic                lookup_en,
    input  wire core_pkg::phys_reg_t alloc_phys,
    input  wire logic                alloc_valid,
    output core_pkg::phys_reg_t      src1_phys,
    output core_pkg::phys_reg_t      src2_phys,
    output core_pkg::phys_reg_t      dest_phys,
    output core_pkg::phys_reg_t      old_phys,
    output core_pkg::arch_reg_t      pending_arch
);

    core_pkg::phys_reg_t map_q [core_pkg::ARCH_REGS];  // Speculative arch -> phys map
    core_pkg::phys_reg_t src1_next;
    core_pkg::phys_reg_t src2_next;
    core_pkg::phys_reg_t old_next;

    // Table read, overridden by the write still in flight from last cycle
    function automatic core_pkg::phys_reg_t bypass_read(
        input core_pkg::arch_reg_t arch,
        input core_pkg::phys_reg_t table_tag,
        input core_pkg::arch_reg_t wr_arch,
        input logic                wr_en,
        input core_pkg::phys_reg_t wr_tag
    );
        if (wr_en && (arch == wr_arch)) bypass_read = wr_tag;
        else bypass_read = table_tag;
    endfunction

    assign src1_next = bypass_read(src1_arch, map_q[src1_arch], pending_arch,
                                   alloc_valid, alloc_phys);
    assign src2_next = bypass_read(src2_arch, map_q[src2_arch], pending_arch,
                                   alloc_valid, alloc_phys);
    assign old_next  = bypass_read(dest_arch, map_q[dest_arch], pending_arch,
                                   alloc_valid, alloc_phys);

    assign dest_phys = alloc_phys;  // New tag comes straight from the free list

    // Map update lands one cycle after the lookup, once allocation is known
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::ARCH_REGS; i++) begin
                map_q[i] <= core_pkg::phys_reg_t'(i);  // Identity mapping
            end
        end else if (alloc_valid) begin
            map_q[pending_arch] <= alloc_phys;
        end
    end

    // Lookup results and the destination to be written next cycle
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            src1_phys    <= src1_next;
            src2_phys    <= src2_next;
            old_phys     <= old_next;
            pending_arch <= dest_arch;
        end
    end

endmodule

`default_nettype wire

// ==== src/retire_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_queue (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                push,
    input  wire core_pkg::arch_reg_t push_arch,
    input  wire core_pkg::phys_reg_t push_old_phys,
    input  wire logic                rename_fail,
    input  wire logic [1:0]          commit_count,
    output logic [1:0]               free_en,
    output core_pkg::phys_reg_t      free_phys0,
    output core_pkg::phys_reg_t      free_phys1,
    output rob_pkg::credit_t         credit_return
);

    // Entry word is {dest arch, old phys}
    typedef logic [$bits(core_pkg::arch_reg_t)+$bits(core_pkg::phys_reg_t)-1:0] entry_t;

    entry_t              mem [rob_pkg::QUEUE_DEPTH];
    rob_pkg::queue_ptr_t head_q;
    rob_pkg::queue_ptr_t tail_q;
    rob_pkg::queue_ptr_t head_p1;  // Second oldest slot
    rob_pkg::queue_ptr_t head_next;
    entry_t              entry0;
    entry_t              entry1;

    // Circular increment over a depth that is not a power of two
    function automatic rob_pkg::queue_ptr_t ptr_inc(input rob_pkg::queue_ptr_t p);
        if (p == rob_pkg::queue_ptr_t'(rob_pkg::QUEUE_DEPTH - 1)) ptr_inc = '0;
        else ptr_inc = p + 1'b1;
    endfunction

    assign head_p1 = ptr_inc(head_q);

    always_comb begin
        case (commit_count)
            2'd1:    head_next = head_p1;
            2'd2:    head_next = ptr_inc(head_p1);
            default: head_next = head_q;  // 3 is never requested
        endcase
    end

    // Two oldest entries offered to the free list
    assign entry0     = mem[head_q];
    assign entry1     = mem[head_p1];
    assign free_phys0 = entry0[$bits(core_pkg::phys_reg_t)-1:0];
    assign free_phys1 = entry1[$bits(core_pkg::phys_reg_t)-1:0];
    assign free_en[0] = (commit_count != 2'd0);
    assign free_en[1] = (commit_count == 2'd2);

    // One credit per retired entry, plus one for a dropped rename
    assign credit_return = rob_pkg::credit_t'(commit_count) + rob_pkg::credit_t'(rename_fail);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_next;
            if (push) tail_q <= ptr_inc(tail_q);
        end
    end

    // Entry write at the tail
    always_ff @(posedge clk) begin
        if (push) mem[tail_q] <= {push_arch, push_old_phys};
    end

endmodule

`default_nettype wire

// ==== src/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int QUEUE_DEPTH  = 24;  // Retire queue slots, also initial credits
    localparam int COMMIT_WIDTH = 2;   // Retirements per cycle

    typedef logic [4:0] queue_ptr_t;  // Head, tail and occupancy
    typedef logic [1:0] credit_t;     // Credits handed back per cycle

endpackage

`default_nettype wire

// ==== verification/tb_rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 30;    // Fill, dry pool and commit tests
    localparam int RANDOM_CYCLES   = 1500;
    localparam int DRAIN_CYCLES    = 30;    // Queue of 24 empties two per cycle
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + DRAIN_CYCLES;
    localparam longint TIMEOUT_NS  = (TOTAL_CYCLES + 100) * 100;

    logic                clk;
    logic                reset;
    logic                rename_req;
    core_pkg::arch_reg_t src1_arch;
    core_pkg::arch_reg_t src2_arch;
    core_pkg::arch_reg_t dest_arch;
    logic [1:0]          commit_count;
    logic                rename_done;
    logic                rename_fail;
    core_pkg::phys_reg_t src1_phys;
    core_pkg::phys_reg_t src2_phys;
    core_pkg::phys_reg_t dest_phys;
    core_pkg::phys_reg_t old_phys;
    logic [1:0]          retire_valid;
    core_pkg::phys_reg_t retired_old_phys0;
    core_pkg::phys_reg_t retired_old_phys1;
    rob_pkg::credit_t    credit_return;

    // Reference model state
    logic [core_pkg::PREGS-1:0] model_free;               // 1 = free
    core_pkg::phys_reg_t        model_map [core_pkg::ARCH_REGS];
    core_pkg::phys_reg_t        model_queue [$];          // Old tags, oldest first
    int                         credits;
    logic                       pend_req;                 // Request made last cycle
    logic                       pend_ok;                  // It found a free register
    core_pkg::phys_reg_t        pend_tag;
    core_pkg::phys_reg_t        pend_src1;
    core_pkg::phys_reg_t        pend_src2;
    core_pkg::phys_reg_t        pend_old;
    core_pkg::arch_reg_t        pend_dest;
    logic [31:0]                rng_state;

    rename_core UUT (
        .clk               (clk),
        .reset             (reset),
        .rename_req        (rename_req),
        .src1_arch         (src1_arch),
        .src2_arch         (src2_arch),
        .dest_arch         (dest_arch),
        .commit_count      (commit_count),
        .rename_done       (rename_done),
        .rename_fail       (rename_fail),
        .src1_phys         (src1_phys),
        .src2_phys         (src2_phys),
        .dest_phys         (dest_phys),
        .old_phys          (old_phys),
        .retire_valid      (retire_valid),
        .retired_old_phys0 (retired_old_phys0),
        .retired_old_phys1 (retired_old_phys1),
        .credit_return     (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // Xorshift32 step on the shared state
    function automatic logic [31:0] random_word();
        logic [31:0] s;
        s = rng_state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rng_state = s;
        return s;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("ERROR: %s", msg);
        $display("=== FAIL ===");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_phys(input string test, input core_pkg::phys_reg_t exp,
                              input core_pkg::phys_reg_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", test, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "tag mismatch");
        end
    endtask

    task automatic check_credit(input string test, input rob_pkg::credit_t exp,
                                input rob_pkg::credit_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", test, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "credit mismatch");
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %b actual %b", test, exp, act);
            $display("=== FAIL ===");
            $fatal(1, "flag mismatch");
        end
    endtask

    // One clock: drive after the edge, check at the falling edge, then advance the model
    task automatic run_cycle(input string name, input logic req, input core_pkg::arch_reg_t s1,
                             input core_pkg::arch_reg_t s2, input core_pkg::arch_reg_t d,
                             input logic [1:0] cc);
        logic             exp_fail;
        rob_pkg::credit_t exp_credit;
        logic             found;
        @(posedge clk);
        #1;
        if (cc > model_queue.size()) stop_on_error("commit count exceeds queued entries");
        if (req) begin
            if (credits <= 0) stop_on_error("rename request issued with no credit left");
            else credits = credits - 1;  // Spent on request
        end
        rename_req   = req;
        src1_arch    = s1;
        src2_arch    = s2;
        dest_arch    = d;
        commit_count = cc;
        @(negedge clk);
        exp_fail = pend_req && !pend_ok;
        check_flag({name, " rename_done"}, pend_req && pend_ok, rename_done);
        check_flag({name, " rename_fail"}, exp_fail, rename_fail);
        if (pend_req && pend_ok) begin
            check_phys({name, " src1_phys"}, pend_src1, src1_phys);
            check_phys({name, " src2_phys"}, pend_src2, src2_phys);
            check_phys({name, " dest_phys"}, pend_tag, dest_phys);
            check_phys({name, " old_phys"}, pend_old, old_phys);
        end
        check_flag({name, " retire_valid[0]"}, cc != 2'd0, retire_valid[0]);
        check_flag({name, " retire_valid[1]"}, cc == 2'd2, retire_valid[1]);
        if (cc >= 2'd1) check_phys({name, " retired_old_phys0"}, model_queue[0], retired_old_phys0);
        if (cc == 2'd2) check_phys({name, " retired_old_phys1"}, model_queue[1], retired_old_phys1);
        exp_credit = rob_pkg::credit_t'(cc) + rob_pkg::credit_t'(exp_fail);
        check_credit({name, " credit_return"}, exp_credit, credit_return);

        // Frees first, so this cycle's allocation can reuse them
        repeat (cc) model_free[model_queue.pop_front()] = 1'b1;
        if (pend_req && pend_ok) begin
            model_map[pend_dest] = pend_tag;  // Same as the bypass seen by this lookup
            model_queue.push_back(pend_old);
        end
        credits = credits + int'(exp_credit);
        if (credits < 0 || credits > rob_pkg::QUEUE_DEPTH)
            stop_on_error($sformatf("credit counter left its range at %0d", credits));
        pend_req = req;
        pend_ok  = 1'b0;
        if (req) begin
            pend_src1 = model_map[s1];
            pend_src2 = model_map[s2];
            pend_old  = model_map[d];
            pend_dest = d;
            found     = 1'b0;
            for (int i = 0; i < core_pkg::PREGS; i++) begin
                if (model_free[i] && !found) begin  // Lowest index first
                    found         = 1'b1;
                    pend_tag      = core_pkg::phys_reg_t'(i);
                    model_free[i] = 1'b0;
                end
            end
            pend_ok = found;
        end
    endtask

    initial begin
        logic [31:0]         r;
        core_pkg::arch_reg_t prev_dest;
        logic                req;
        logic [1:0]          cc;
        rename_req   = 1'b0;
        src1_arch    = '0;
        src2_arch    = '0;
        dest_arch    = '0;
        commit_count = 2'd0;
        reset        = 1'b1;
        rng_state    = 32'h71f26238;
        credits      = rob_pkg::QUEUE_DEPTH;
        pend_req     = 1'b0;
        pend_ok      = 1'b0;
        prev_dest    = '0;
        for (int i = 0; i < core_pkg::PREGS; i++) model_free[i] = (i >= core_pkg::ARCH_REGS);
        for (int i = 0; i < core_pkg::ARCH_REGS; i++) model_map[i] = core_pkg::phys_reg_t'(i);
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        // Fill all 16 spare registers, src1 always reads last cycle's destination
        for (int i = 0; i < 16; i++) begin
            r = random_word();
            run_cycle("fill", 1'b1, prev_dest, r[9:5], r[4:0], 2'd0);
            prev_dest = r[4:0];
        end

        // Pool is dry now
        run_cycle("dry_pool", 1'b1, 5'd1, 5'd2, 5'd3, 2'd0);
        run_cycle("dry_pool", 1'b1, 5'd3, 5'd4, 5'd5, 2'd0);
        run_cycle("dry_pool_idle", 1'b0, '0, '0, '0, 2'd0);

        // Retire one, then two, each with a rename that only the freed tags can serve
        run_cycle("commit_one_alloc", 1'b1, 5'd2, 5'd6, 5'd2, 2'd1);
        run_cycle("commit_two_alloc", 1'b1, 5'd3, 5'd5, 5'd3, 2'd2);
        run_cycle("commit_idle", 1'b0, '0, '0, '0, 2'd0);

        // Random mix, requests limited by credits, commits by queue fill
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            r   = random_word();
            req = (r[1:0] != 2'd0) && (credits > 0);
            cc  = (r[21:20] == 2'd3) ? 2'd0 : r[21:20];
            if (int'(cc) > model_queue.size()) cc = 2'(model_queue.size());
            run_cycle("random", req, r[8:4], r[13:9], r[18:14], cc);
        end

        // Retire everything still in flight
        while (model_queue.size() > 0 || pend_req) begin
            cc = (model_queue.size() >= 2) ? 2'd2 : 2'(model_queue.size());
            run_cycle("drain", 1'b0, '0, '0, '0, cc);
        end
        if (credits != rob_pkg::QUEUE_DEPTH) begin
            stop_on_error($sformatf("credits total %0d after drain instead of %0d",
                                    credits, rob_pkg::QUEUE_DEPTH));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire
